// File: Makefile
BIN = obj_dir/VmipsTb

all: run

$(BIN): all.f $(wildcard verilog/*.sv verilog/*.svh bench/*.sv)
	verilator --binary --assert -Wno-fatal -j 0 --top-module mipsTb -f all.f

run: $(BIN)
	./$(BIN) +verilator+error+limit+100 | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: all.f
+incdir+verilog
verilog/mipsPkg.sv
verilog/mipsControl.sv
verilog/mipsFetch.sv
verilog/mipsRegFile.sv
verilog/mipsExecute.sv
verilog/mipsCore.sv
bench/mipsCore_asserts.sv
bench/mipsChecker.sv
bench/mipsTb.sv

// File: bench/mipsChecker.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module mipsChecker (
	input logic Clk,
	input logic Reset,
	input mipsPkg::wordT image [256],
	input mipsPkg::wordT MemAddr,
	input mipsPkg::wordT MemWData,
	input logic MemWrite,
	input logic Halted,
	output logic done,
	output int valueErrors,
	output int countErrors
);
	import mipsPkg::*;

	wordT expAddr [$];
	wordT expData [$];
	int storeIdx;

	// Instruction level run of the program that returns 0 if break is never reached
	function automatic bit executeProgram();
		wordT regs [`NUM_REGS];
		wordT dmem [256];
		wordT pc;
		wordT ir;
		wordT rsV;
		wordT rtV;
		wordT sext;
		wordT addr;
		bit stop;
		int steps;
		regs = '{default: '0};
		dmem = image;
		pc = `PC_RESET;
		stop = 1'b0;
		for (steps = 0; steps < 1000 && !stop; steps++) begin
			ir = dmem[pc[9:2]];
			pc = pc + 32'd4;
			rsV = regs[ir[25:21]];
			rtV = regs[ir[20:16]];
			sext = {{16{ir[15]}}, ir[15:0]};
			addr = rsV + sext;
			case (opcodeT'(ir[31:26]))
				OpRType: begin
					case (functT'(ir[5:0]))
						FnAdd: regs[ir[15:11]] = rsV + rtV;
						FnSub: regs[ir[15:11]] = rsV - rtV;
						FnAnd: regs[ir[15:11]] = rsV & rtV;
						FnOr: regs[ir[15:11]] = rsV | rtV;
						FnXor: regs[ir[15:11]] = rsV ^ rtV;
						FnBreak: stop = 1'b1;
						default: ;
					endcase
				end
				OpAddi: regs[ir[20:16]] = rsV + sext;
				OpXori: regs[ir[20:16]] = rsV ^ {16'h0000, ir[15:0]}; // Zero-extended
				OpLw: regs[ir[20:16]] = dmem[addr[9:2]];
				OpSw: begin
					dmem[addr[9:2]] = rtV;
					expAddr.push_back(addr);
					expData.push_back(rtV);
				end
				OpBeq: begin
					if (rsV == rtV)
						pc = pc + (sext << 2);
				end
				OpBne: begin
					if (rsV != rtV)
						pc = pc + (sext << 2);
				end
				OpJ: pc = {pc[31:28], ir[25:0], 2'b00};
				default: ;
			endcase
			regs[0] = '0; // Register 0 always reads zero
		end
		return stop;
	endfunction

	initial begin
		$timeformat(-9, 0, " ns", 0);
		done = 1'b0;
		valueErrors = 0;
		countErrors = 0;
		storeIdx = 0;
		@(negedge Reset);
		if (!executeProgram()) begin
			$display("ERROR: reference model never reached the break instruction");
			countErrors++;
		end
		// A store seen here lands on the next rising edge
		forever begin
			@(negedge Clk);
			if (MemWrite && !done) begin
				if (storeIdx >= expAddr.size()) begin
					$display("CHECK FAILED at %0t: unexpected store [%h]=%h",
						$time, MemAddr, MemWData);
					valueErrors++;
				end else if (MemAddr !== expAddr[storeIdx] || MemWData !== expData[storeIdx]) begin
					$display("CHECK FAILED at %0t: store %0d expected [%h]=%h, got [%h]=%h",
						$time, storeIdx, expAddr[storeIdx], expData[storeIdx], MemAddr, MemWData);
					valueErrors++;
				end
				storeIdx++;
			end
			if (Halted && !done) begin
				if (storeIdx != expAddr.size()) begin
					$display("CHECK FAILED at %0t: %0d stores seen, %0d expected",
						$time, storeIdx, expAddr.size());
					countErrors++;
				end
				done = 1'b1;
			end
		end
	end

endmodule

// File: bench/mipsCore_asserts.sv
`timescale 1ns/10ps

module mipsCoreAsserts (
	input logic Clk,
	input logic Reset,
	input logic MemWrite,
	input logic Halted
);
	int failCount = 0;

	// Stores are single cycle strobes
	assert property (@(posedge Clk) disable iff (Reset) MemWrite |=> !MemWrite)
	else begin
		failCount++;
		$error("MemWrite high on two consecutive cycles");
	end

	assert property (@(posedge Clk) disable iff (Reset) Halted |-> !MemWrite)
	else begin
		failCount++;
		$error("MemWrite high while halted");
	end

	// Halt is sticky until reset
	assert property (@(posedge Clk) disable iff (Reset) Halted |=> Halted)
	else begin
		failCount++;
		$error("Halted dropped without reset");
	end

	assert property (@(posedge Clk) Reset |-> !MemWrite && !Halted)
	else begin
		failCount++;
		$error("MemWrite or Halted high during reset");
	end

endmodule

bind mipsCore mipsCoreAsserts i_mipsCoreAsserts (
	.Clk(Clk), .Reset(Reset), .MemWrite(MemWrite), .Halted(Halted)
);

// File: bench/mipsTb.sv
`timescale 1ns/10ps

module mipsTb;
	import mipsPkg::*;

	localparam int memWords = 256;
	localparam logic [31:0] seed = 32'ha6e60183;

	logic Clk;
	logic Reset;
	wordT MemRData;
	wordT MemAddr;
	wordT MemWData;
	logic MemWrite;
	logic Halted;

	wordT mem [memWords];
	wordT image [memWords]; // Program and data before the run
	logic [7:0] rdIndex;
	logic [31:0] rng;
	int progLen;
	int storeSlot;
	logic checkDone;
	int valueErrors;
	int countErrors;

	mipsCore i_mipsCore (
		.Clk(Clk), .Reset(Reset), .MemRData(MemRData), .MemAddr(MemAddr),
		.MemWData(MemWData), .MemWrite(MemWrite), .Halted(Halted)
	);

	mipsChecker i_mipsChecker (
		.Clk(Clk), .Reset(Reset), .image(image), .MemAddr(MemAddr),
		.MemWData(MemWData), .MemWrite(MemWrite), .Halted(Halted),
		.done(checkDone), .valueErrors(valueErrors), .countErrors(countErrors)
	);

	always #50 Clk = ~Clk;

	// Single port memory that takes its address at the rising edge
	always @(posedge Clk) begin
		if (MemWrite)
			mem[MemAddr[9:2]] <= MemWData;
		rdIndex <= MemAddr[9:2];
	end

	always @(negedge Clk)
		MemRData <= mem[rdIndex]; // Read data for the next rising edge

	function automatic logic [31:0] xorshift32(logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic wordT encodeR(functT funct, int rs, int rt, int rd);
		return {OpRType, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
	endfunction

	function automatic wordT encodeI(opcodeT op, int rs, int rt, logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	task automatic emit(wordT word);
		image[progLen] = word;
		progLen++;
	endtask

	// Each store gets its own slot below the base in r10
	task automatic storeReg(int rt, output logic [15:0] offset);
		rng = xorshift32(rng);
		offset = 16'hff80 + 16'(8 * storeSlot) + {13'd0, rng[0], 2'b00};
		storeSlot++;
		emit(encodeI(OpSw, 10, rt, offset));
	endtask

	task automatic buildProgram();
		functT ops [5] = '{FnAdd, FnSub, FnAnd, FnOr, FnXor};
		logic [15:0] offset;
		logic [15:0] lwOffset;
		int srcA;
		int srcB;
		int k;
		rng = seed;
		progLen = 0;
		storeSlot = 0;
		for (k = 0; k < memWords; k++)
			image[k] = 32'hd00d_0000 | 32'(k << 2); // Byte address in the low half
		rng = xorshift32(rng);
		emit(encodeI(OpAddi, 0, 1, rng[15:0] | 16'h8000)); // Negative immediate
		rng = xorshift32(rng);
		emit(encodeI(OpAddi, 0, 2, rng[15:0]));
		emit(encodeI(OpAddi, 0, 3, rng[31:16]));
		emit(encodeI(OpAddi, 0, 10, 16'h0300)); // Data base
		emit(encodeI(OpAddi, 0, 13, 16'h0bad)); // Marker value
		storeReg(1, offset);
		for (k = 0; k < 5; k++) begin
			rng = xorshift32(rng);
			srcA = 1 + int'(rng[7:0]) % (3 + k);
			srcB = 1 + (srcA + int'(rng[15:8]) % (2 + k)) % (3 + k); // Never equal to srcA
			emit(encodeR(ops[k], srcA, srcB, 4 + k));
			storeReg(4 + k, offset);
			if (k == 0)
				lwOffset = offset;
		end
		rng = xorshift32(rng);
		emit(encodeI(OpXori, 1 + int'(rng[7:0]) % 8, 9, rng[31:16] | 16'h8000));
		storeReg(9, offset);
		emit(encodeI(OpLw, 10, 11, lwOffset)); // Reads back the add result
		emit(encodeR(FnAdd, 11, 9, 12));
		storeReg(12, offset);
		// A taken branch skips the marker store after it
		emit(encodeI(OpBeq, 4, 4, 16'd1));
		storeReg(13, offset);
		emit(encodeI(OpBeq, 4, 5, 16'd1));
		storeReg(13, offset);
		emit(encodeI(OpBne, 4, 5, 16'd1));
		storeReg(13, offset);
		emit(encodeI(OpBne, 6, 6, 16'd1));
		storeReg(13, offset);
		emit({OpJ, 26'(progLen + 2)});
		storeReg(13, offset);
		storeReg(12, offset);
		emit(encodeR(FnBreak, 0, 0, 0));
	endtask

	initial begin
		@(negedge Reset);
		repeat (9 * progLen + 100) @(posedge Clk);
		$display("ERROR: core never halted within %0d cycles after reset", 9 * progLen + 100);
		$display("test failed");
		$finish;
	end

	initial begin
		Clk = 1'b0;
		Reset = 1'b1;
		MemRData = '0;
		buildProgram();
		mem = image;
		repeat (10) @(negedge Clk);
		Reset = 1'b0;
		wait (checkDone);
		@(negedge Clk);
		$display("Errors: %0d store, %0d count, %0d assertion", valueErrors, countErrors,
			i_mipsCore.i_mipsCoreAsserts.failCount);
		if (valueErrors + countErrors + i_mipsCore.i_mipsCoreAsserts.failCount == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: verilog/mipsControl.sv
`timescale 1ns/10ps

module mipsControl (
	input logic Clk,
	input logic Reset,
	input mipsPkg::instrFieldsT instr,
	input logic zero,
	output mipsPkg::ctrlT ctrl,
	output logic Halted
);
	import mipsPkg::*;

	ctrlStateT state;
	ctrlStateT nextState;
	aluOpT rAluOp;

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			state <= Fetch;
		end else begin
			state <= nextState;
		end
	end

	// R-type ALU operation from funct
	always_comb begin
		case (instr.funct)
			FnSub: rAluOp = AluSub;
			FnAnd: rAluOp = AluAnd;
			FnOr: rAluOp = AluOr;
			FnXor: rAluOp = AluXor;
			default: rAluOp = AluAdd;
		endcase
	end

	always_comb begin
		case (state)
			Fetch: nextState = FetchWait;
			FetchWait: nextState = FetchLoad;
			FetchLoad: nextState = Decode;
			Decode: begin
				case (instr.opcode)
					OpRType: nextState = (instr.funct == FnBreak) ? Halt : RType;
					OpAddi, OpXori: nextState = ImmOp;
					OpLw, OpSw: nextState = MemAddr;
					OpBeq, OpBne: nextState = Branch;
					OpJ: nextState = Jump;
					default: nextState = Fetch; // Unknown opcode skipped
				endcase
			end
			RType: nextState = RTypeWb;
			ImmOp: nextState = ImmWb;
			MemAddr: nextState = (instr.opcode == OpLw) ? LoadRead : StoreWrite;
			LoadRead: nextState = LoadWait;
			LoadWait: nextState = LoadMdr;
			LoadMdr: nextState = LoadWb;
			Halt: nextState = Halt; // Sticky until reset
			default: nextState = Fetch;
		endcase
	end

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = AluAdd;
		case (state)
			FetchLoad: begin
				ctrl.irWrite = 1'b1;
				ctrl.pcWrite = 1'b1;
				ctrl.aluSrcB = 2'b01; // PC + step
				ctrl.pcSource = 2'b00;
			end
			Decode: begin
				ctrl.aWrite = 1'b1;
				ctrl.bWrite = 1'b1;
				ctrl.aluSrcB = 2'b11; // Branch target ahead of time
				ctrl.aluOutLoad = 1'b1;
			end
			RType: begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = 2'b00;
				ctrl.aluOp = rAluOp;
				ctrl.aluOutLoad = 1'b1;
			end
			RTypeWb: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = 1'b1; // Write rd
				ctrl.memToReg = 2'b00;
			end
			ImmOp: begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = 2'b10;
				ctrl.aluOp = (instr.opcode == OpXori) ? AluXor : AluAdd;
				ctrl.aluOutLoad = 1'b1;
			end
			ImmWb: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 2'b00;
			end
			MemAddr: begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = 2'b10; // Base plus offset
				ctrl.aluOutLoad = 1'b1;
			end
			LoadRead, LoadWait: begin
				ctrl.iorD = 1'b1;
			end
			LoadMdr: begin
				ctrl.iorD = 1'b1;
				ctrl.mdrLoad = 1'b1;
			end
			LoadWb: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 2'b01; // Loaded word
			end
			StoreWrite: begin
				ctrl.iorD = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			Branch: begin
				// Compare A and B, take ALUOut target on match
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = 2'b00;
				ctrl.aluOp = AluSub;
				ctrl.pcSource = 2'b01;
				ctrl.pcWrite = (instr.opcode == OpBne) ? ~zero : zero;
			end
			Jump: begin
				ctrl.pcWrite = 1'b1;
				ctrl.pcSource = 2'b10;
			end
			default: begin
				ctrl.aluOp = AluAdd; // Fetch, FetchWait and Halt drive no strobes
			end
		endcase
	end

	assign Halted = (state == Halt);

endmodule

// File: verilog/mipsCore.sv
`timescale 1ns/10ps

module mipsCore (
	input logic Clk,
	input logic Reset,
	input mipsPkg::wordT MemRData,
	output mipsPkg::wordT MemAddr,
	output mipsPkg::wordT MemWData,
	output logic MemWrite,
	output logic Halted
);
	import mipsPkg::*;

	ctrlT ctrl;
	instrFieldsT instr;
	wordT pc;
	wordT aluResult;
	wordT aluOut;
	wordT wrData;
	wordT rsData;
	wordT rtData;
	logic zero;

	mipsControl i_mipsControl (
		.Clk(Clk), .Reset(Reset), .instr(instr), .zero(zero),
		.ctrl(ctrl), .Halted(Halted)
	);

	mipsFetch i_mipsFetch (
		.Clk(Clk), .Reset(Reset), .ctrl(ctrl), .MemRData(MemRData),
		.aluResult(aluResult), .aluOut(aluOut),
		.instr(instr), .pc(pc), .MemAddr(MemAddr)
	);

	mipsRegFile i_mipsRegFile (
		.Clk(Clk), .Reset(Reset), .ctrl(ctrl), .instr(instr),
		.wrData(wrData), .rsData(rsData), .rtData(rtData)
	);

	mipsExecute i_mipsExecute (
		.Clk(Clk), .Reset(Reset), .ctrl(ctrl), .instr(instr),
		.pc(pc), .MemRData(MemRData), .rsData(rsData), .rtData(rtData),
		.aluResult(aluResult), .aluOut(aluOut), .wrData(wrData),
		.MemWData(MemWData), .zero(zero)
	);

	assign MemWrite = ctrl.memWrite;

endmodule

// File: verilog/mipsExecute.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module mipsExecute (
	input logic Clk,
	input logic Reset,
	input mipsPkg::ctrlT ctrl,
	input mipsPkg::instrFieldsT instr,
	input mipsPkg::wordT pc,
	input mipsPkg::wordT MemRData,
	input mipsPkg::wordT rsData,
	input mipsPkg::wordT rtData,
	output mipsPkg::wordT aluResult,
	output mipsPkg::wordT aluOut,
	output mipsPkg::wordT wrData,
	output mipsPkg::wordT MemWData,
	output logic zero
);
	import mipsPkg::*;

	wordT aReg;
	wordT bReg;
	wordT mdr;
	wordT immSext;
	wordT immExt;
	wordT immShift;
	wordT srcA;
	wordT srcB;

	assign immSext = {{(`WORD_W-16){instr.imm16[15]}}, instr.imm16};
	// xori is the only zero-extending immediate
	assign immExt = (instr.opcode == OpXori) ?
		{{(`WORD_W-16){1'b0}}, instr.imm16} : immSext;
	assign immShift = immSext << 2; // Word offset to byte offset

	assign srcA = ctrl.aluSrcA ? aReg : pc;

	always_comb begin
		case (ctrl.aluSrcB)
			2'b00: srcB = bReg;
			2'b01: srcB = `PC_STEP;
			2'b10: srcB = immExt;
			default: srcB = immShift;
		endcase
	end

	always_comb begin
		case (ctrl.aluOp)
			AluSub: aluResult = srcA - srcB;
			AluAnd: aluResult = srcA & srcB;
			AluOr: aluResult = srcA | srcB;
			AluXor: aluResult = srcA ^ srcB;
			default: aluResult = srcA + srcB;
		endcase
	end

	assign zero = (aluResult == '0); // Equality for branches

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			aReg <= '0;
			bReg <= '0;
			aluOut <= '0;
			mdr <= '0;
		end else begin
			if (ctrl.aWrite)
				aReg <= rsData;
			if (ctrl.bWrite)
				bReg <= rtData;
			if (ctrl.aluOutLoad)
				aluOut <= aluResult;
			if (ctrl.mdrLoad)
				mdr <= MemRData;
		end
	end

	assign wrData = (ctrl.memToReg == 2'b01) ? mdr : aluOut;
	assign MemWData = bReg; // Store data is rt

endmodule

// File: verilog/mipsFetch.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module mipsFetch (
	input logic Clk,
	input logic Reset,
	input mipsPkg::ctrlT ctrl,
	input mipsPkg::wordT MemRData,
	input mipsPkg::wordT aluResult,
	input mipsPkg::wordT aluOut,
	output mipsPkg::instrFieldsT instr,
	output mipsPkg::wordT pc,
	output mipsPkg::wordT MemAddr
);
	import mipsPkg::*;

	wordT ir;
	wordT nextPc;
	wordT jumpTarget;

	// Region bits of PC kept for j
	assign jumpTarget = {pc[`WORD_W-1:`WORD_W-4], instr.target26, 2'b00};

	always_comb begin
		case (ctrl.pcSource)
			2'b01: nextPc = aluOut; // Branch target from Decode
			2'b10: nextPc = jumpTarget;
			default: nextPc = aluResult;
		endcase
	end

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			pc <= `PC_RESET;
			ir <= '0;
		end else begin
			if (ctrl.pcWrite)
				pc <= nextPc;
			if (ctrl.irWrite)
				ir <= MemRData;
		end
	end

	assign MemAddr = ctrl.iorD ? aluOut : pc;

	always_comb begin
		instr.opcode = opcodeT'(ir[31:26]);
		instr.rs = ir[25:21];
		instr.rt = ir[20:16];
		instr.rd = ir[15:11];
		instr.funct = functT'(ir[5:0]);
		instr.imm16 = ir[15:0];
		instr.target26 = ir[25:0];
	end

endmodule

// File: verilog/mipsPkg.sv
`include "mips_consts.svh"

package mipsPkg;

	typedef logic [`WORD_W-1:0] wordT;

	typedef enum logic [5:0] {
		OpRType = 6'h00,
		OpJ = 6'h02,
		OpBeq = 6'h04,
		OpBne = 6'h05,
		OpAddi = 6'h08,
		OpXori = 6'h0e,
		OpLw = 6'h23,
		OpSw = 6'h2b
	} opcodeT;

	typedef enum logic [5:0] {
		FnBreak = 6'h0d,
		FnAdd = 6'h20,
		FnSub = 6'h22,
		FnAnd = 6'h24,
		FnOr = 6'h25,
		FnXor = 6'h26
	} functT;

	typedef enum logic [2:0] {AluAdd, AluSub, AluAnd, AluOr, AluXor} aluOpT;

	typedef enum logic [4:0] {
		Fetch, FetchWait, FetchLoad, Decode,
		RType, RTypeWb,
		ImmOp, ImmWb,
		MemAddr, LoadRead, LoadWait, LoadMdr, LoadWb, StoreWrite,
		Branch, Jump, Halt
	} ctrlStateT;

	// Decoded views of the instruction register
	typedef struct packed {
		opcodeT opcode;
		logic [`REG_ADDR_W-1:0] rs;
		logic [`REG_ADDR_W-1:0] rt;
		logic [`REG_ADDR_W-1:0] rd;
		functT funct;
		logic [15:0] imm16;
		logic [25:0] target26;
	} instrFieldsT;

	typedef struct packed {
		logic pcWrite;
		logic [1:0] pcSource; // 0 ALU result, 1 ALUOut, 2 jump target
		logic iorD; // Memory address from ALUOut
		logic irWrite;
		logic aluSrcA; // 0 PC, 1 register A
		logic [1:0] aluSrcB; // 0 B, 1 step, 2 imm, 3 imm << 2
		aluOpT aluOp;
		logic aluOutLoad;
		logic aWrite;
		logic bWrite;
		logic mdrLoad;
		logic regWrite;
		logic regDst; // 0 rt, 1 rd
		logic [1:0] memToReg; // 0 ALUOut, 1 MDR
		logic memWrite;
	} ctrlT;

endpackage

// File: verilog/mipsRegFile.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module mipsRegFile (
	input logic Clk,
	input logic Reset,
	input mipsPkg::ctrlT ctrl,
	input mipsPkg::instrFieldsT instr,
	input mipsPkg::wordT wrData,
	output mipsPkg::wordT rsData,
	output mipsPkg::wordT rtData
);
	import mipsPkg::*;

	wordT regs [`NUM_REGS];
	logic [`REG_ADDR_W-1:0] wrAddr;

	assign wrAddr = ctrl.regDst ? instr.rd : instr.rt;

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			for (int i = 0; i < `NUM_REGS; i++)
				regs[i] <= '0;
		end else if (ctrl.regWrite && (wrAddr != '0)) begin
			regs[wrAddr] <= wrData; // $0 never written
		end
	end

	assign rsData = regs[instr.rs];
	assign rtData = regs[instr.rt];

endmodule

// File: verilog/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// Datapath and address width
`define WORD_W 32

// Register file geometry
`define REG_ADDR_W 5
`define NUM_REGS 32

// First instruction address
`define PC_RESET 32'h0000_0000

// Sequential instruction stride in bytes
`define PC_STEP 32'd4

`endif
